// ==== design/eth_tx_settings.svh ====
`ifndef ETH_TX_SETTINGS_SVH
`define ETH_TX_SETTINGS_SVH

// buffer geometry
`define ETH_ADDR_W 11
`define ETH_BUF_DEPTH 1536

// frame layout in bytes
`define ETH_PRE_LEN 8
`define ETH_HDR_LEN 14

// ieee 802.3 crc-32
`define ETH_CRC_POLY 32'h04C11DB7
`define ETH_CRC_INIT 32'hFFFFFFFF

`endif

// ==== design/eth_tx_pkg.sv ====
`include "eth_tx_settings.svh"

package eth_tx_pkg;

   // host write into the frame buffer
   typedef struct packed {
      logic                   en;
      logic [`ETH_ADDR_W-1:0] addr;
      logic [7:0]             data;
   } buf_wr_t;

   typedef struct packed {
      logic [`ETH_ADDR_W-1:0] addr;
   } buf_rd_t;

   // MII transmit pins
   typedef struct packed {
      logic       en;
      logic [3:0] data;
   } mii_tx_t;

   typedef struct packed {
      logic clear;
      logic en;
   } crc_ctl_t;

endpackage

// ==== design/eth_tx_sync.sv ====
`include "eth_tx_settings.svh"

module eth_tx_sync (
   input  logic                   TX_CLK,
   input  logic                   rst,
   input  logic                   send,
   input  logic [`ETH_ADDR_W-1:0] nbytes,
   output logic                   tx_rst,
   output logic                   send_sync,
   output logic [`ETH_ADDR_W-1:0] nbytes_sync
);

   logic                   rst_meta;
   logic                   send_meta;
   logic [`ETH_ADDR_W-1:0] nbytes_meta;

   // async assert, release after two edges
   always_ff @(posedge TX_CLK or posedge rst) begin
      if (rst) begin
         rst_meta <= 1'b1;
         tx_rst   <= 1'b1;
      end else begin
         rst_meta <= 1'b0;
         tx_rst   <= rst_meta;
      end
   end

   // send sets the flag at once, clears two edges after it drops
   always_ff @(posedge TX_CLK or posedge send) begin
      if (send) begin
         send_meta <= 1'b1;
         send_sync <= 1'b1;
      end else begin
         send_meta <= 1'b0;
         send_sync <= send_meta;
      end
   end

   // host holds nbytes stable for the whole frame
   always_ff @(posedge TX_CLK) begin
      nbytes_meta <= nbytes;
      nbytes_sync <= nbytes_meta;
   end

endmodule

// ==== design/eth_frame_buf.sv ====
`include "eth_tx_settings.svh"

module eth_frame_buf
   import eth_tx_pkg::*;
(
   input  logic       clk,
   input  logic       TX_CLK,
   input  buf_wr_t    wr,
   input  buf_rd_t    rd,
   output logic [7:0] rd_data
);

   logic [7:0] mem [`ETH_BUF_DEPTH];

   // host side write port
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // registered read, data one cycle after address
   always_ff @(posedge TX_CLK) begin
      rd_data <= mem[rd.addr];
   end

endmodule

// ==== design/eth_crc.sv ====
`include "eth_tx_settings.svh"

module eth_crc
   import eth_tx_pkg::*;
(
   input  logic        TX_CLK,
   input  logic        tx_rst,
   input  crc_ctl_t    ctl,
   input  logic [7:0]  data,
   output logic [31:0] crc
);

   // one byte, lsb first, non-reflected register
   function automatic logic [31:0] crc_byte(input logic [31:0] c_in,
                                            input logic [7:0]  d);
      logic [31:0] c;
      logic        fb;
      c = c_in;
      for (int i = 0; i < 8; i++) begin
         fb = c[31] ^ d[i];
         c  = {c[30:0], 1'b0};
         if (fb) begin
            c = c ^ `ETH_CRC_POLY;
         end
      end
      return c;
   endfunction

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         crc <= `ETH_CRC_INIT;
      end else if (ctl.clear) begin
         crc <= `ETH_CRC_INIT;
      end else if (ctl.en) begin
         crc <= crc_byte(crc, data);
      end
   end

endmodule

// ==== design/eth_tx_mii.sv ====
`include "eth_tx_settings.svh"

module eth_tx_mii
   import eth_tx_pkg::*;
(
   input  logic                   TX_CLK,
   input  logic                   tx_rst,
   input  logic                   send_sync,
   input  logic [`ETH_ADDR_W-1:0] nbytes_sync,
   output buf_rd_t                rd,
   input  logic [7:0]             rd_data,
   output crc_ctl_t               crc_ctl,
   input  logic [31:0]            crc,
   output mii_tx_t                tx,
   output logic                   ready
);

   localparam logic [2:0] PH_IDLE = 3'd0;
   localparam logic [2:0] PH_PRE  = 3'd1;
   localparam logic [2:0] PH_DATA = 3'd2;
   localparam logic [2:0] PH_FCS  = 3'd3;
   localparam logic [2:0] PH_END  = 3'd4;

   localparam logic [`ETH_ADDR_W-1:0] PRE_END = `ETH_PRE_LEN;

   logic [2:0]             phase;
   logic                   hi;
   logic [2:0]             fcs_cnt;
   logic [`ETH_ADDR_W-1:0] addr;
   logic [`ETH_ADDR_W-1:0] frame_end;
   logic [31:0]            fcs;
   logic [3:0]             nib_next;
   logic                   tx_en;
   logic [3:0]             tx_data;

   function automatic logic [7:0] rev_byte(input logic [7:0] b);
      logic [7:0] r;
      for (int i = 0; i < 8; i++) begin
         r[i] = b[7 - i];
      end
      return r;
   endfunction

   // total bytes in buffer, preamble through payload
   assign frame_end = `ETH_ADDR_W'(`ETH_PRE_LEN + `ETH_HDR_LEN) + nbytes_sync;

   // reflected and inverted, so fcs[7:0] is the first byte on the wire
   assign fcs = ~{rev_byte(crc[7:0]), rev_byte(crc[15:8]),
                  rev_byte(crc[23:16]), rev_byte(crc[31:24])};

   always_comb begin
      if (phase == PH_FCS) begin
         nib_next = fcs[{fcs_cnt, 2'b00} +: 4];
      end else if (hi) begin
         nib_next = rd_data[7:4];
      end else begin
         nib_next = rd_data[3:0];
      end
   end

   // crc sees each byte on its high nibble
   assign crc_ctl = '{clear: (phase == PH_IDLE) && send_sync,
                      en:    (phase == PH_DATA) && hi};
   assign rd      = '{addr: addr};
   assign tx      = '{en: tx_en, data: tx_data};

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         phase   <= PH_IDLE;
         hi      <= 1'b0;
         fcs_cnt <= 3'd0;
         addr    <= '0;
         tx_en   <= 1'b0;
         ready   <= 1'b1;
      end else begin
         case (phase)
            PH_IDLE: begin
               if (send_sync) begin
                  ready <= 1'b0;
                  phase <= PH_PRE;
               end
            end
            PH_PRE: begin
               tx_en <= 1'b1;
               hi    <= ~hi;
               // next byte is fetched while the low nibble goes out
               if (!hi) begin
                  addr <= addr + 1'b1;
               end else if (addr == PRE_END) begin
                  phase <= PH_DATA;
               end
            end
            PH_DATA: begin
               hi <= ~hi;
               if (!hi) begin
                  addr <= addr + 1'b1;
               end else if (addr == frame_end) begin
                  phase <= PH_FCS;
               end
            end
            PH_FCS: begin
               fcs_cnt <= fcs_cnt + 1'b1;
               if (fcs_cnt == 3'd7) begin
                  phase <= PH_END;
               end
            end
            PH_END: begin
               tx_en <= 1'b0;
               ready <= 1'b1;
               addr  <= '0;
               phase <= PH_IDLE;
            end
            default: phase <= PH_IDLE;
         endcase
      end
   end

   // nibble register, only meaningful while tx_en is high
   always_ff @(posedge TX_CLK) begin
      tx_data <= nib_next;
   end

endmodule

// ==== design/eth_tx_top.sv ====
`include "eth_tx_settings.svh"

module eth_tx_top
   import eth_tx_pkg::*;
(
   input  logic                   clk,
   input  logic                   TX_CLK,
   input  logic                   rst,
   input  buf_wr_t                wr,
   input  logic [`ETH_ADDR_W-1:0] nbytes,
   input  logic                   send,
   output logic                   ready,
   output logic                   TX_EN,
   output logic [3:0]             TX_DATA
);

   logic                   tx_rst;
   logic                   send_sync;
   logic [`ETH_ADDR_W-1:0] nbytes_sync;
   buf_rd_t                rd;
   logic [7:0]             rd_data;
   crc_ctl_t               crc_ctl;
   logic [31:0]            crc;
   mii_tx_t                tx;

   eth_tx_sync u_sync (
      .TX_CLK      (TX_CLK),
      .rst         (rst),
      .send        (send),
      .nbytes      (nbytes),
      .tx_rst      (tx_rst),
      .send_sync   (send_sync),
      .nbytes_sync (nbytes_sync)
   );

   eth_frame_buf u_buf (
      .clk     (clk),
      .TX_CLK  (TX_CLK),
      .wr      (wr),
      .rd      (rd),
      .rd_data (rd_data)
   );

   eth_crc u_crc (
      .TX_CLK (TX_CLK),
      .tx_rst (tx_rst),
      .ctl    (crc_ctl),
      .data   (rd_data),
      .crc    (crc)
   );

   eth_tx_mii u_mii (
      .TX_CLK      (TX_CLK),
      .tx_rst      (tx_rst),
      .send_sync   (send_sync),
      .nbytes_sync (nbytes_sync),
      .rd          (rd),
      .rd_data     (rd_data),
      .crc_ctl     (crc_ctl),
      .crc         (crc),
      .tx          (tx),
      .ready       (ready)
   );

   // MII pins
   assign TX_EN   = tx.en;
   assign TX_DATA = tx.data;

endmodule

// ==== dv/eth_tx_tb.sv ====
`include "eth_tx_settings.svh"

module eth_tx_tb
   import eth_tx_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int PRE = `ETH_PRE_LEN;
   localparam int HDR = `ETH_HDR_LEN;
   localparam int N_RAND = 4;
   localparam int N_FRAMES = N_RAND + 4;
   localparam int MAX_F = PRE + HDR + 200;
   localparam int FRAME_CYC = 2 * (MAX_F + 4) + 40;
   // tx time per frame plus host write time per frame
   localparam int WATCHDOG_NS = N_FRAMES * (FRAME_CYC * 40 + MAX_F * 30) + 40 * 40;
   // dest, source, ethertype
   localparam logic [111:0] HDR_BYTES = 112'h020000000001_020000000002_88B5;

   logic                   clk = 1'b0;
   logic                   TX_CLK = 1'b0;
   logic                   rst;
   buf_wr_t                wr;
   logic [`ETH_ADDR_W-1:0] nbytes;
   logic                   send;
   logic                   ready;
   logic                   TX_EN;
   logic [3:0]             TX_DATA;

   logic [31:0] lfsr = 32'h0e7bcfaf;
   logic [7:0]  exp_bytes [0:`ETH_BUF_DEPTH+3];
   int          exp_len;
   logic [7:0]  mon_exp [0:`ETH_BUF_DEPTH+3];
   int          mon_len;
   int          errors = 0;
   int          sends_accepted = 0;
   int          frames_seen = 0;
   int          nib_cnt = 0;
   logic [3:0]  low_nib;
   logic        en_prev = 1'b0;
   logic        abort_pending = 1'b0;

   eth_tx_top uut (
      .clk     (clk),
      .TX_CLK  (TX_CLK),
      .rst     (rst),
      .wr      (wr),
      .nbytes  (nbytes),
      .send    (send),
      .ready   (ready),
      .TX_EN   (TX_EN),
      .TX_DATA (TX_DATA)
   );

   always #20 TX_CLK = ~TX_CLK;
   always #15 clk = ~clk;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // fibonacci lfsr stepped once per bit on taps 32 22 2 1
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   // bitwise reflected crc-32 as sent on the wire
   function automatic logic [31:0] ref_crc(input int first, input int last);
      logic [31:0] c;
      c = 32'hFFFFFFFF;
      for (int i = first; i <= last; i++) begin
         c = c ^ {24'h0, exp_bytes[i]};
         for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
               c = (c >> 1) ^ 32'hEDB88320;
            end else begin
               c = c >> 1;
            end
         end
      end
      return ~c;
   endfunction

   task automatic build_frame(input int n);
      int          f;
      logic [31:0] r;
      logic [31:0] fcs;
      f = PRE + HDR + n;
      for (int i = 0; i < PRE - 1; i++) begin
         exp_bytes[i] = 8'h55;
      end
      exp_bytes[PRE-1] = 8'hD5;
      for (int k = 0; k < HDR; k++) begin
         exp_bytes[PRE+k] = HDR_BYTES[111-8*k -: 8];
      end
      for (int i = PRE + HDR; i < f; i++) begin
         r = lfsr_bits(8);
         exp_bytes[i] = r[7:0];
      end
      fcs = ref_crc(PRE, f - 1);
      for (int k = 0; k < 4; k++) begin
         exp_bytes[f+k] = fcs[8*k +: 8];
      end
      exp_len = f + 4;
   endtask

   task automatic wait_ready(input logic level, input int limit, input string what);
      int k;
      k = 0;
      while (ready !== level && k < limit) begin
         @(posedge clk);
         k++;
      end
      if (ready !== level) begin
         errors++;
         $display("ERROR at %0t: %s", $time, what);
      end
   endtask

   task automatic send_frame(input int n, input bit stray_send, input bit abort);
      int f;
      f = PRE + HDR + n;
      build_frame(n);
      @(posedge clk);
      #2;
      nbytes = `ETH_ADDR_W'(n);
      for (int i = 0; i < f; i++) begin
         @(posedge clk);
         check("ready", 32'(ready), 32'd1);
         #2;
         wr = '{en: 1'b1, addr: `ETH_ADDR_W'(i), data: exp_bytes[i]};
      end
      @(posedge clk);
      #2;
      wr.en = 1'b0;
      send  = 1'b1;
      @(posedge clk);
      #2;
      send = 1'b0;
      sends_accepted++;
      wait_ready(1'b0, 20, "ready did not fall after send");
      if (stray_send) begin
         // must be ignored while the frame is on the wire
         repeat (10) @(posedge clk);
         #2;
         send = 1'b1;
         @(posedge clk);
         #2;
         send = 1'b0;
      end
      if (abort) begin
         repeat (20) @(posedge clk);
         #2;
         abort_pending = 1'b1;
         rst = 1'b1;
         #1;
         check("TX_EN", 32'(TX_EN), 32'd0);
         check("ready", 32'(ready), 32'd1);
         repeat (3) @(posedge TX_CLK);
         @(posedge clk);
         #2;
         rst = 1'b0;
      end else begin
         wait_ready(1'b1, 3 * (f + 4) + 40, "ready did not return at the end of a frame");
      end
   endtask

   // capture MII nibbles on the falling edge of TX_CLK
   always @(negedge TX_CLK) begin
      if (TX_EN) begin
         if (!en_prev) begin
            frames_seen++;
            nib_cnt = 0;
            mon_len = exp_len;
            for (int i = 0; i < exp_len; i++) begin
               mon_exp[i] = exp_bytes[i];
            end
         end
         check("ready", 32'(ready), 32'd0);
         if ((nib_cnt % 2) == 0) begin
            low_nib = TX_DATA;
         end else if (nib_cnt / 2 < mon_len) begin
            check($sformatf("TX_DATA byte %0d", nib_cnt / 2),
                  32'({TX_DATA, low_nib}), 32'(mon_exp[nib_cnt/2]));
         end
         nib_cnt++;
      end else if (en_prev) begin
         check("ready", 32'(ready), 32'd1);
         if (abort_pending) begin
            abort_pending = 1'b0;
         end else begin
            check("TX_EN cycles", 32'(nib_cnt), 32'(2 * mon_len));
         end
      end
      en_prev = TX_EN;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired at %0t, the DUT stopped finishing frames", $time);
      $display("tests failed");
      $finish;
   end

   initial begin
      int          n;
      logic [31:0] r;
      rst    = 1'b1;
      send   = 1'b0;
      nbytes = '0;
      wr     = '0;
      repeat (10) @(posedge TX_CLK);
      @(posedge clk);
      #2;
      rst = 1'b0;
      repeat (4) @(posedge TX_CLK);
      @(posedge clk);
      check("ready", 32'(ready), 32'd1);
      check("TX_EN", 32'(TX_EN), 32'd0);

      // fixed header with minimum payload
      send_frame(46, 1'b0, 1'b0);

      for (int k = 0; k < N_RAND; k++) begin
         r = lfsr_bits(8);
         n = 46 + int'(r[7:0]) % 155;
         send_frame(n, 1'b0, 1'b0);
      end

      send_frame(60, 1'b1, 1'b0);

      // reset mid frame and then send a clean frame
      send_frame(100, 1'b0, 1'b1);
      send_frame(46, 1'b0, 1'b0);

      repeat (4) @(posedge TX_CLK);
      check("frames seen", 32'(frames_seen), 32'(sends_accepted));
      $display("errors %0d, frames seen %0d, sends accepted %0d",
               errors, frames_seen, sends_accepted);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== eth_tx.f ====
+incdir+design
design/eth_tx_pkg.sv
design/eth_tx_sync.sv
design/eth_frame_buf.sv
design/eth_crc.sv
design/eth_tx_mii.sv
design/eth_tx_top.sv
dv/eth_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the eth_tx testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
   -f eth_tx.f --top-module eth_tx_tb -o eth_tx_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/eth_tx_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1
